// File: testbench/accum_input.txt
# name rst | operand: sgn scale frac inf zero | expected: sgn scale frac inf zero truncated
# Scales in decimal, operand fraction 26-bit hex, expected fraction 34-bit hex
single_after_reset 1  0 5  2000000 0 0  0 5  200000000 0 0 0
carry_equal        0  0 5  2000000 0 0  0 6  200000000 0 0 0
carry_mixed        0  0 6  1000000 0 0  0 7  180000000 0 0 0
cancel_partial     0  1 7  1400000 0 0  0 3  000000000 0 0 0
cancel_exact       0  1 3  0000000 0 0  1 3  000000000 0 1 0
large_sum          0  0 50 0000000 0 0  0 50 000000000 0 0 0
far_below          0  0 10 2000000 0 0  0 50 000000000 0 0 1
partial_shift      0  0 20 0000001 0 0  0 50 000000010 0 0 1
zero_operand       0  0 7  1234567 0 1  0 50 000000010 0 0 0
inf_operand        0  0 48 0000000 1 0  0 50 100000010 1 0 0
inf_sticks         0  0 50 0000000 0 0  0 51 080000008 1 0 0
reset_zero         1  0 0  0000000 0 1  0 0  000000000 0 1 0
single_negative    0  1 12 3ffffff 0 0  1 12 3ffffff00 0 0 0
carry_negative     0  1 12 0000001 0 0  1 13 200000000 0 0 0
sign_flip          0  0 13 3000040 0 0  0 11 000010000 0 0 0

// File: verilog.f
+incdir+design
design/posit_pkg.sv
design/posit_align.sv
design/posit_fraction_addsub.sv
design/posit_lod.sv
design/posit_normalize.sv
design/posit_accum_raw.sv
testbench/posit_accum_clock.sv
testbench/posit_accum_props.sv
testbench/posit_accum_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module posit_accum_tb \
    -o posit_accum_sim

./obj_dir/posit_accum_sim | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log
then
    echo "Simulation passed"
else
    echo "Simulation did not pass, see sim.log"
    exit 1
fi

// File: testbench/posit_accum_tb.sv
////////////////////////////////////////////////////////////
// Testbench top for the raw posit accumulator: reads
// operands and expected sums, drives the DUT and checks
////////////////////////////////////////////////////////////
`include "posit_macros.svh"

module posit_accum_tb import posit_pkg::*; ();

    localparam int DONE_CYCLES = 1 + 2 + `POSIT_ADDSUB_LATENCY + 2 + 1;
    localparam int DONE_TIMEOUT = 50;
    localparam int RESET_CYCLES = 10;

    logic         clk;
    logic         rst;
    logic         start;
    raw_operand_t in1;
    value_accum_t result;
    logic         done;
    logic         truncated;

    int passed;
    int failed;
    int file_errors;

    posit_accum_clock u_clock (
        .clk (clk)
    );

    posit_accum_raw u_dut (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .in1       (in1),
        .result    (result),
        .done      (done),
        .truncated (truncated)
    );

    function automatic string format_sum(input value_accum_t v);
        return $sformatf("sgn=%0d scale=%0d frac=%h inf=%0d zero=%0d",
            v.sgn, v.scale, v.fraction, v.inf, v.zero);
    endfunction

    task automatic apply_reset();
        int n;
        @(negedge clk);
        rst = 1'b1;
        n = 0;
        while (n < RESET_CYCLES)
        begin
            @(negedge clk);
            n++;
        end
        rst = 1'b0;
    endtask

    // One operand per call, start held for a single cycle
    task automatic run_test(
        input string        name,
        input raw_operand_t op,
        input value_accum_t exp_sum,
        input logic         exp_trunc
    );
        int cycles;
        bit test_ok;
        test_ok = 1'b1;
        @(negedge clk);
        start = 1'b1;
        in1 = op;
        @(negedge clk);
        start = 1'b0;
        in1 = '0;
        // The edge that sampled start counts as the first
        cycles = 1;
        while (!done && cycles < DONE_TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!done)
        begin
            $display("Timeout: done never came for test %s", name);
            test_ok = 1'b0;
        end
        else
        begin
            if (cycles != DONE_CYCLES)
            begin
                $display("Fail %s latency expected %0d actual %0d", name, DONE_CYCLES, cycles);
                test_ok = 1'b0;
            end
            if (result !== exp_sum)
            begin
                $display("Fail %s result expected %s actual %s",
                    name, format_sum(exp_sum), format_sum(result));
                test_ok = 1'b0;
            end
            if (truncated !== exp_trunc)
            begin
                $display("Fail %s truncated expected %0d actual %0d", name, exp_trunc, truncated);
                test_ok = 1'b0;
            end
        end
        if (test_ok)
        begin
            passed++;
            $display("Pass %s", name);
        end
        else
            failed++;
    endtask

    initial
    begin
        int                            fd;
        int                            fields;
        int                            rst_flag;
        int                            op_sgn;
        int                            op_scale;
        int                            op_inf;
        int                            op_zero;
        int                            exp_sgn;
        int                            exp_scale;
        int                            exp_inf;
        int                            exp_zero;
        int                            exp_trunc;
        logic [`POSIT_FBITS-1:0]       op_frac;
        logic [`POSIT_FBITS_ACCUM-1:0] exp_frac;
        raw_operand_t                  op;
        value_accum_t                  exp_sum;
        string                         line;
        string                         name;

        rst = 1'b1;
        start = 1'b0;
        in1 = '0;
        passed = 0;
        failed = 0;
        file_errors = 0;
        apply_reset();

        fd = $fopen("testbench/accum_input.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the stimulus file testbench/accum_input.txt");
            file_errors++;
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line.substr(0, 0) == "#")
                    continue;
                fields = $sscanf(line, "%s %d %d %d %h %d %d %d %d %h %d %d %d",
                    name, rst_flag, op_sgn, op_scale, op_frac, op_inf, op_zero,
                    exp_sgn, exp_scale, exp_frac, exp_inf, exp_zero, exp_trunc);
                if (fields != 13)
                begin
                    $display("Malformed line in the stimulus file: %s", line);
                    file_errors++;
                end
                else
                begin
                    if (rst_flag != 0)
                        apply_reset();
                    op = '{
                        sgn:      op_sgn[0],
                        scale:    op_scale[`POSIT_SCALE_BITS-1:0],
                        fraction: op_frac,
                        inf:      op_inf[0],
                        zero:     op_zero[0]
                    };
                    exp_sum = '{
                        sgn:      exp_sgn[0],
                        scale:    exp_scale[`POSIT_SCALE_BITS-1:0],
                        fraction: exp_frac,
                        inf:      exp_inf[0],
                        zero:     exp_zero[0]
                    };
                    run_test(name, op, exp_sum, exp_trunc[0]);
                end
            end
            $fclose(fd);
        end

        $display("Tests: %0d run, %0d passed, %0d failed", passed + failed, passed, failed);
        if (failed == 0 && file_errors == 0 && passed > 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: testbench/posit_accum_props.sv
////////////////////////////////////////////////////////////
// Concurrent assertions on start/done timing and reset
// values, bound into the accumulator top
////////////////////////////////////////////////////////////
`include "posit_macros.svh"

module posit_accum_props (
    input logic clk,
    input logic rst,
    input logic start,
    input logic done,
    input logic truncated
);

    // Capture, align, adder, normalize and output register
    localparam int DONE_DELAY = 1 + 2 + `POSIT_ADDSUB_LATENCY + 2 + 1;

    property p_done_latency;
        @(posedge clk) disable iff (rst)
        start |-> ##DONE_DELAY done;
    endproperty

    property p_reset_outputs;
        @(posedge clk)
        rst |-> (!done && !truncated);
    endproperty

    // One operand in flight gives a single-cycle done
    property p_done_single;
        @(posedge clk) disable iff (rst)
        done |=> !done;
    endproperty

    a_done_latency: assert property (p_done_latency)
        else $error("done did not follow start after %0d cycles", DONE_DELAY);

    a_reset_outputs: assert property (p_reset_outputs)
        else $error("done or truncated high during reset");

    a_done_single: assert property (p_done_single)
        else $error("done high for two cycles in a row");

endmodule

bind posit_accum_raw posit_accum_props u_props (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .done      (done),
    .truncated (truncated)
);

// File: testbench/posit_accum_clock.sv
////////////////////////////////////////////////////////////
// Free-running testbench clock, period of 4 time units
////////////////////////////////////////////////////////////
module posit_accum_clock (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

endmodule

// File: design/posit_accum_raw.sv
////////////////////////////////////////////////////////////
// Raw posit accumulator top: capture stage, adder delay
// line, output register and accumulator feedback
////////////////////////////////////////////////////////////
`include "posit_macros.svh"

module posit_accum_raw import posit_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         start,
    input  raw_operand_t in1,
    output value_accum_t result,
    output logic         done,
    output logic         truncated
);

    localparam int LAT = `POSIT_ADDSUB_LATENCY;
    localparam int PAD = `POSIT_FBITS_ACCUM - `POSIT_FBITS;
    localparam value_accum_t ACCUM_ZERO = '{
        sgn: 1'b0, scale: '0, fraction: '0, inf: 1'b0, zero: 1'b1
    };

    logic          r0_valid;
    value_accum_t  r0_a;
    value_accum_t  accum;

    logic          align_valid;
    aligned_pair_t pair;
    logic [`POSIT_ABITS_ACCUM:0] sum_raw;

    value_accum_t    hi_dly [LAT];
    logic [LAT-1:0]  valid_dly;
    logic [LAT-1:0]  low_zero_dly;
    logic [LAT-1:0]  low_inf_dly;
    logic [LAT-1:0]  sticky_dly;

    logic [8:0]    lod_pos;
    logic          lod_found;
    logic [8:0]    lead_pos;

    logic          norm_valid;
    value_accum_t  norm_sum;
    logic          norm_sticky;

    // Stage 0: capture, idle cycles feed a zero operand
    always_ff @(posedge clk, posedge rst)
    begin
        if (rst)
            r0_valid <= 1'b0;
        else
            r0_valid <= start;
    end

    always_ff @(posedge clk)
    begin
        if (in1.zero || !start)
            r0_a <= ACCUM_ZERO;
        else
            r0_a <= '{
                sgn:      in1.sgn,
                scale:    in1.scale,
                fraction: {in1.fraction, {PAD{1'b0}}},
                inf:      in1.inf,
                zero:     1'b0
            };
    end

    // Running sum takes each finished result
    always_ff @(posedge clk, posedge rst)
    begin
        if (rst)
            accum <= ACCUM_ZERO;
        else if (done)
            accum <= result;
    end

    posit_align u_align (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (r0_valid),
        .a         (r0_a),
        .accum     (accum),
        .valid_out (align_valid),
        .pair      (pair)
    );

    posit_fraction_addsub u_addsub (
        .clk (clk),
        .rst (rst),
        .op  (pair.op),
        .a   ({~pair.hi.zero, pair.hi.fraction, {`POSIT_GUARD_BITS{1'b0}}}),
        .b   (pair.low_frac),
        .sum (sum_raw)
    );

    // Delay line matched to the adder latency
    always_ff @(posedge clk, posedge rst)
    begin
        if (rst)
            valid_dly <= '0;
        else
            valid_dly <= {valid_dly[LAT-2:0], align_valid};
    end

    always_ff @(posedge clk)
    begin
        hi_dly[0] <= pair.hi;
        for (int i = 1; i < LAT; i++)
        begin
            hi_dly[i] <= hi_dly[i-1];
        end
        low_zero_dly <= {low_zero_dly[LAT-2:0], pair.low_zero};
        low_inf_dly <= {low_inf_dly[LAT-2:0], pair.low_inf};
        sticky_dly <= {sticky_dly[LAT-2:0], pair.sticky};
    end

    posit_lod u_lod (
        .value (sum_raw),
        .pos   (lod_pos),
        .found (lod_found)
    );

    // An all-zero sum counts every bit as a leading zero
    assign lead_pos = lod_found ? lod_pos : 9'(`POSIT_ABITS_ACCUM + 1);

    posit_normalize u_norm (
        .clk        (clk),
        .rst        (rst),
        .valid_in   (valid_dly[LAT-1]),
        .hi         (hi_dly[LAT-1]),
        .low_zero   (low_zero_dly[LAT-1]),
        .low_inf    (low_inf_dly[LAT-1]),
        .sticky_in  (sticky_dly[LAT-1]),
        .sum_raw    (sum_raw),
        .lead_pos   (lead_pos),
        .valid_out  (norm_valid),
        .sum        (norm_sum),
        .sticky_out (norm_sticky)
    );

    // Output register, result holds between operands
    always_ff @(posedge clk, posedge rst)
    begin
        if (rst)
        begin
            result <= ACCUM_ZERO;
            done <= 1'b0;
            truncated <= 1'b0;
        end
        else
        begin
            done <= norm_valid;
            if (norm_valid)
            begin
                result <= norm_sum;
                truncated <= norm_sticky;
            end
        end
    end

endmodule

// File: design/posit_normalize.sv
////////////////////////////////////////////////////////////
// Scale correction and flag merge, then left shift of
// the fraction sum past its leading one
////////////////////////////////////////////////////////////
`include "posit_macros.svh"

module posit_normalize import posit_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        valid_in,
    input  value_accum_t                hi,
    input  logic                        low_zero,
    input  logic                        low_inf,
    input  logic                        sticky_in,
    input  logic [`POSIT_ABITS_ACCUM:0] sum_raw,
    input  logic [8:0]                  lead_pos,
    output logic                        valid_out,
    output value_accum_t                sum,
    output logic                        sticky_out
);

    localparam int A = `POSIT_ABITS_ACCUM;
    localparam logic signed [`POSIT_SCALE_BITS-1:0] SCALE_ONE =
        {{(`POSIT_SCALE_BITS-1){1'b0}}, 1'b1};

    logic                                sum_zero;
    logic signed [`POSIT_SCALE_BITS-1:0] scale_next;

    logic                                valid1;
    logic                                sgn1;
    logic signed [`POSIT_SCALE_BITS-1:0] scale1;
    logic                                inf1;
    logic                                zero1;
    logic                                sticky1;
    logic [A:0]                          sum_raw1;
    logic [9:0]                          shamt1;
    logic [A:0]                          sum_shifted;

    // Exact cancellation also yields zero
    assign sum_zero = (hi.zero & low_zero) | ~|sum_raw;

    always_comb
    begin
        if (sum_raw[A])
            scale_next = hi.scale + SCALE_ONE;
        else if (!sum_raw[A-1] && !sum_zero)
            scale_next = hi.scale - lead_pos + SCALE_ONE;
        else
            scale_next = hi.scale;
    end

    always_ff @(posedge clk, posedge rst)
    begin
        if (rst)
        begin
            valid1 <= 1'b0;
            valid_out <= 1'b0;
        end
        else
        begin
            valid1 <= valid_in;
            valid_out <= valid1;
        end
    end

    // Stage 1: sign, scale and flags
    always_ff @(posedge clk)
    begin
        sgn1 <= hi.sgn;
        scale1 <= scale_next;
        inf1 <= hi.inf | low_inf;
        zero1 <= sum_zero;
        sticky1 <= sticky_in;
        sum_raw1 <= sum_raw;
        shamt1 <= {1'b0, lead_pos} + 10'd1;
    end

    // Shift the leading one out, the hidden bit is implicit
    assign sum_shifted = sum_raw1 << shamt1;

    // Stage 2: keep the top fraction bits
    always_ff @(posedge clk)
    begin
        sum <= '{
            sgn:      sgn1,
            scale:    scale1,
            fraction: sum_shifted[A -: `POSIT_FBITS_ACCUM],
            inf:      inf1,
            zero:     zero1
        };
        sticky_out <= sticky1;
    end

endmodule

// File: design/posit_lod.sv
////////////////////////////////////////////////////////////
// Leading-one search on the raw fraction sum
////////////////////////////////////////////////////////////
`include "posit_macros.svh"

module posit_lod import posit_pkg::*; (
    input  logic [`POSIT_ABITS_ACCUM:0] value,
    output logic [8:0]                  pos,
    output logic                        found
);

    localparam int W = `POSIT_ABITS_ACCUM + 1;

    // Scan upwards so the highest set bit wins
    always_comb
    begin
        pos = '0;
        found = 1'b0;
        for (int i = 0; i < W; i++)
        begin
            if (value[i])
            begin
                pos = 9'(W - 1 - i);
                found = 1'b1;
            end
        end
    end

endmodule

// File: design/posit_fraction_addsub.sv
////////////////////////////////////////////////////////////
// Pipelined add or subtract of the aligned fractions
////////////////////////////////////////////////////////////
`include "posit_macros.svh"

module posit_fraction_addsub import posit_pkg::*; (
    input  logic                          clk,
    input  logic                          rst,
    input  accum_op_e                     op,
    input  logic [`POSIT_ABITS_ACCUM-1:0] a,
    input  logic [`POSIT_ABITS_ACCUM-1:0] b,
    output logic [`POSIT_ABITS_ACCUM:0]   sum
);

    localparam int LAT = `POSIT_ADDSUB_LATENCY;

    logic [`POSIT_ABITS_ACCUM:0] a_ext;
    logic [`POSIT_ABITS_ACCUM:0] b_ext;
    logic [`POSIT_ABITS_ACCUM:0] result;
    logic [`POSIT_ABITS_ACCUM:0] stage [LAT];

    assign a_ext = {1'b0, a};
    assign b_ext = {1'b0, b};

    // a is never smaller than b, so the difference stays positive
    assign result = (op == ACC_ADD) ? a_ext + b_ext : a_ext - b_ext;

    // The trailing registers let synthesis retime the adder
    always_ff @(posedge clk, posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < LAT; i++)
            begin
                stage[i] <= '0;
            end
        end
        else
        begin
            stage[0] <= result;
            for (int i = 1; i < LAT; i++)
            begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign sum = stage[LAT-1];

endmodule

// File: design/posit_align.sv
////////////////////////////////////////////////////////////
// Operand alignment: magnitude compare and swap, then
// right shift of the smaller fraction with sticky bit
////////////////////////////////////////////////////////////
`include "posit_macros.svh"

module posit_align import posit_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          valid_in,
    input  value_accum_t  a,
    input  value_accum_t  accum,
    output logic          valid_out,
    output aligned_pair_t pair
);

    localparam int ABITS = `POSIT_ABITS_ACCUM;
    localparam int SB = `POSIT_SCALE_BITS;
    localparam logic [9:0] SHIFT_MAX = 10'(`POSIT_ABITS_ACCUM);

    // Magnitude keys: zero sorts lowest, scale in offset binary
    logic [SB+`POSIT_FBITS_ACCUM:0] key_a;
    logic [SB+`POSIT_FBITS_ACCUM:0] key_acc;
    logic                           a_is_hi;

    value_accum_t hi1;
    value_accum_t low1;
    accum_op_e    op1;
    logic         valid1;

    logic [9:0]         diff;
    logic [9:0]         shamt;
    logic [ABITS-1:0]   low_mant;
    logic [2*ABITS-1:0] low_ext;

    assign key_a = {~a.zero, ~a.scale[SB-1], a.scale[SB-2:0], a.fraction};
    assign key_acc = {~accum.zero, ~accum.scale[SB-1], accum.scale[SB-2:0], accum.fraction};
    assign a_is_hi = key_a >= key_acc;

    always_ff @(posedge clk, posedge rst)
    begin
        if (rst)
        begin
            valid1 <= 1'b0;
            valid_out <= 1'b0;
        end
        else
        begin
            valid1 <= valid_in;
            valid_out <= valid1;
        end
    end

    // Stage 1: swap so the larger magnitude is hi
    always_ff @(posedge clk)
    begin
        hi1 <= a_is_hi ? a : accum;
        low1 <= a_is_hi ? accum : a;
        op1 <= (a.sgn == accum.sgn) ? ACC_ADD : ACC_SUB;
    end

    // A negative difference only occurs against a zero low value
    assign diff = {hi1.scale[SB-1], hi1.scale} - {low1.scale[SB-1], low1.scale};
    assign shamt = (diff >= SHIFT_MAX) ? SHIFT_MAX : diff;
    assign low_mant = {~low1.zero, low1.fraction, {`POSIT_GUARD_BITS{1'b0}}};
    assign low_ext = {low_mant, {ABITS{1'b0}}} >> shamt;

    // Stage 2: shifted low fraction, lower half becomes sticky
    always_ff @(posedge clk)
    begin
        pair <= '{
            hi:       hi1,
            low_zero: low1.zero,
            low_inf:  low1.inf,
            op:       op1,
            low_frac: low_ext[2*ABITS-1:ABITS],
            sticky:   |low_ext[ABITS-1:0]
        };
    end

endmodule

// File: design/posit_pkg.sv
////////////////////////////////////////////////////////////
// Raw operand, accumulator and aligned pair structs
// Add/subtract opcode
////////////////////////////////////////////////////////////
`include "posit_macros.svh"

package posit_pkg;

    // Equal signs add the fractions, unequal signs subtract
    typedef enum logic {
        ACC_SUB = 1'b0,
        ACC_ADD = 1'b1
    } accum_op_e;

    // Serialized input layout, sgn in the MSB and zero in the LSB
    typedef struct packed {
        logic                                sgn;
        logic signed [`POSIT_SCALE_BITS-1:0] scale;
        logic [`POSIT_FBITS-1:0]             fraction;
        logic                                inf;
        logic                                zero;
    } raw_operand_t;

    // Running sum and the format used inside the pipeline
    typedef struct packed {
        logic                                sgn;
        logic signed [`POSIT_SCALE_BITS-1:0] scale;
        logic [`POSIT_FBITS_ACCUM-1:0]       fraction;
        logic                                inf;
        logic                                zero;
    } value_accum_t;

    // Align output towards the fraction adder
    typedef struct packed {
        value_accum_t                   hi;
        logic                           low_zero;
        logic                           low_inf;
        accum_op_e                      op;
        logic [`POSIT_ABITS_ACCUM-1:0]  low_frac;
        logic                           sticky;
    } aligned_pair_t;

endpackage

// File: design/posit_macros.svh
////////////////////////////////////////////////////////////
// Field widths of the raw posit and accumulator formats
// Adder operand width and adder pipeline latency
////////////////////////////////////////////////////////////
`ifndef POSIT_MACROS_SVH
`define POSIT_MACROS_SVH

// Raw operand and accumulator fields
`define POSIT_FBITS 26
`define POSIT_FBITS_ACCUM 34
`define POSIT_SCALE_BITS 9

// Hidden bit, accumulator fraction and guard bits
`define POSIT_GUARD_BITS 3
`define POSIT_ABITS_ACCUM (1 + `POSIT_FBITS_ACCUM + `POSIT_GUARD_BITS)

// Register stages in the fraction adder
`define POSIT_ADDSUB_LATENCY 4

// Serialized port widths: sgn, scale, fraction, inf, zero
`define POSIT_RAW_WIDTH (1 + `POSIT_SCALE_BITS + `POSIT_FBITS + 1 + 1)
`define POSIT_ACCUM_WIDTH (1 + `POSIT_SCALE_BITS + `POSIT_FBITS_ACCUM + 1 + 1)

`endif
